// File: src/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// one queued LCD bus word
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_cmd_t;

	// init config {lines, font, display_on, cursor, blink, inc_dec, shift}
	localparam int CFG_W      = 7;
	localparam int CFG_LINES  = 6;
	localparam int CFG_FONT   = 5;
	localparam int CFG_DISP   = 4;
	localparam int CFG_CURSOR = 3;
	localparam int CFG_BLINK  = 2;
	localparam int CFG_INC    = 1;
	localparam int CFG_SHIFT  = 0;

	localparam int FIFO_DEPTH = 8;
	localparam int PTR_W      = $clog2(FIFO_DEPTH);
	localparam int LVL_W      = 4;                 // holds 0 to FIFO_DEPTH

	// wishbone register map
	localparam int   WB_DW      = 16;
	localparam logic ADR_CMD    = 1'b0;
	localparam logic ADR_STATUS = 1'b1;
	localparam int   STAT_BUSY  = 8;               // busy bit in status word

	// delays in clock cycles
	localparam int T_POWERUP  = 200;
	localparam int T_EN_SETUP = 2;
	localparam int T_EN_HIGH  = 6;
	localparam int T_CMD      = 40;
	localparam int T_CLEAR    = 120;

	localparam int CNT_MAX = (T_POWERUP > T_CLEAR) ? T_POWERUP : T_CLEAR;
	localparam int CNT_W   = $clog2(CNT_MAX);

	// init step indices
	localparam int INIT_CLEAR = 2;
	localparam int INIT_LAST  = 3;

endpackage

`default_nettype wire

// File: src/wb_cmd_slave.sv
`timescale 1ns/1ps
`default_nettype none

module wb_cmd_slave import lcd_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              wb_cyc,
	input  wire              wb_stb,
	input  wire              wb_we,
	input  wire              wb_adr,
	input  wire [WB_DW-1:0]  wb_dat_w,
	input  wire              push_ready,
	input  wire [LVL_W-1:0]  level,
	input  wire              busy,
	output logic [WB_DW-1:0] wb_dat_r,
	output logic             wb_ack,
	output logic             push_valid,
	output lcd_cmd_t         push_cmd
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_PUSH,
		S_ACK
	} state_t;

	state_t state;
	logic   access;
	logic   cmd_write;
	logic   status_read;

	assign access      = wb_cyc && wb_stb;
	assign cmd_write   = wb_we && (wb_adr == ADR_CMD);
	assign status_read = !wb_we && (wb_adr == ADR_STATUS);

	assign wb_ack     = (state == S_ACK);   // one cycle, then back to idle
	assign push_valid = (state == S_PUSH);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (access) begin
						if (cmd_write)
							state <= S_PUSH;
						else
							state <= S_ACK;     // status access or ignored write
					end
				end
				S_PUSH: begin
					if (push_ready)
						state <= S_ACK;         // held here while fifo is full
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// capture write word and status at start of access
	always_ff @(posedge clk) begin
		if (state == S_IDLE && access) begin
			push_cmd.rs   <= wb_dat_w[9];
			push_cmd.rw   <= wb_dat_w[8];
			push_cmd.data <= wb_dat_w[7:0];
			wb_dat_r      <= '0;
			if (status_read) begin
				wb_dat_r[STAT_BUSY]   <= busy;
				wb_dat_r[LVL_W-1:0]   <= level;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo import lcd_pkg::*; #(
	parameter type T = lcd_cmd_t
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              push_valid,
	input  wire T            push_data,
	input  wire              pop_ready,
	output logic             push_ready,
	output logic             pop_valid,
	output T                 pop_data,
	output logic [LVL_W-1:0] level
);

	T                 mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [LVL_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push_ready = (count != LVL_W'(FIFO_DEPTH));
	assign pop_valid  = (count != '0);
	assign do_push    = push_valid && push_ready;
	assign do_pop     = pop_valid && pop_ready;
	assign pop_data   = mem[rd_ptr];          // head of queue
	assign level      = count;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;      // none, or push and pop together
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/lcd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl import lcd_pkg::*; (
	input  wire             clk,
	input  wire             rst_n,
	input  wire [CFG_W-1:0] init_cfg,
	input  wire             pop_valid,
	input  wire lcd_cmd_t   pop_cmd,
	output logic            pop_ready,
	output logic            lcd_e,
	output logic            lcd_rs,
	output logic            lcd_rw,
	output logic [7:0]      lcd_data,
	output logic            busy
);

	typedef enum logic [1:0] {
		S_POWERUP,
		S_INIT,
		S_IDLE,
		S_WRITE
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_nxt;
	logic [1:0]       step;
	logic [1:0]       step_nxt;
	logic [CNT_W-1:0] slot_last;
	logic             slot_done;

	// init command bytes built from the config input
	function automatic logic [7:0] init_word(input logic [1:0] idx,
	                                         input logic [CFG_W-1:0] cfg);
		logic [7:0] w;
		case (idx)
			2'd0:    w = {4'b0011, cfg[CFG_LINES], cfg[CFG_FONT], 2'b00};       // function set
			2'd1:    w = {5'b00001, cfg[CFG_DISP], cfg[CFG_CURSOR], cfg[CFG_BLINK]};
			2'd2:    w = 8'b0000_0001;                                          // clear
			default: w = {6'b000001, cfg[CFG_INC], cfg[CFG_SHIFT]};             // entry mode
		endcase
		return w;
	endfunction

	// e is high for a fixed window inside each slot
	function automatic logic en_window(input logic [CNT_W-1:0] k);
		return (k >= CNT_W'(T_EN_SETUP)) && (k < CNT_W'(T_EN_SETUP + T_EN_HIGH));
	endfunction

	assign pop_ready = (state == S_IDLE);
	assign cnt_nxt   = cnt + 1'b1;
	assign step_nxt  = step + 2'd1;

	// clear needs the long slot
	assign slot_last = (state == S_INIT && step == 2'(INIT_CLEAR)) ?
	                   CNT_W'(T_CLEAR - 1) : CNT_W'(T_CMD - 1);
	assign slot_done = (cnt == slot_last);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_POWERUP;
			cnt      <= '0;
			step     <= '0;
			lcd_e    <= 1'b0;
			lcd_rs   <= 1'b0;
			lcd_rw   <= 1'b0;
			lcd_data <= '0;
			busy     <= 1'b1;              // busy until init is through
		end else begin
			case (state)
				S_POWERUP: begin
					if (cnt == CNT_W'(T_POWERUP - 1)) begin
						cnt      <= '0;
						step     <= '0;
						lcd_data <= init_word(2'd0, init_cfg);
						state    <= S_INIT;
					end else begin
						cnt <= cnt_nxt;
					end
				end

				S_INIT: begin
					if (slot_done) begin
						lcd_e <= 1'b0;
						cnt   <= '0;
						if (step == 2'(INIT_LAST)) begin
							lcd_data <= '0;
							busy     <= 1'b0;
							state    <= S_IDLE;
						end else begin
							step     <= step_nxt;
							lcd_data <= init_word(step_nxt, init_cfg);
						end
					end else begin
						cnt   <= cnt_nxt;
						lcd_e <= en_window(cnt_nxt);
					end
				end

				S_IDLE: begin
					if (pop_valid) begin          // pop_ready is high here
						lcd_rs   <= pop_cmd.rs;
						lcd_rw   <= pop_cmd.rw;
						lcd_data <= pop_cmd.data;
						busy     <= 1'b1;
						cnt      <= '0;
						state    <= S_WRITE;
					end
				end

				S_WRITE: begin
					if (slot_done) begin
						// bus returns to zero between slots
						lcd_e    <= 1'b0;
						lcd_rs   <= 1'b0;
						lcd_rw   <= 1'b0;
						lcd_data <= '0;
						busy     <= 1'b0;
						cnt      <= '0;
						state    <= S_IDLE;
					end else begin
						cnt   <= cnt_nxt;
						lcd_e <= en_window(cnt_nxt);
					end
				end

				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_top import lcd_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire [CFG_W-1:0]  init_cfg,
	input  wire              wb_cyc,
	input  wire              wb_stb,
	input  wire              wb_we,
	input  wire              wb_adr,
	input  wire [WB_DW-1:0]  wb_dat_w,
	output logic [WB_DW-1:0] wb_dat_r,
	output logic             wb_ack,
	output logic             lcd_e,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic [7:0]       lcd_data,
	output logic             busy
);

	logic             push_valid;
	logic             push_ready;
	lcd_cmd_t         push_cmd;
	logic             pop_valid;
	logic             pop_ready;
	lcd_cmd_t         pop_cmd;
	logic [LVL_W-1:0] level;

	wb_cmd_slave i_slave (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.push_ready (push_ready),
		.level      (level),        // fill level for status reads
		.busy       (busy),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.push_valid (push_valid),
		.push_cmd   (push_cmd)
	);

	cmd_fifo #(
		.T (lcd_cmd_t)
	) i_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push_valid (push_valid),
		.push_data  (push_cmd),
		.pop_ready  (pop_ready),
		.push_ready (push_ready),
		.pop_valid  (pop_valid),
		.pop_data   (pop_cmd),
		.level      (level)
	);

	lcd_ctrl i_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.init_cfg  (init_cfg),
		.pop_valid (pop_valid),
		.pop_cmd   (pop_cmd),
		.pop_ready (pop_ready),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data),
		.busy      (busy)
	);

endmodule

`default_nettype wire

// File: testbench/tb_lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_top import lcd_pkg::*; ();

	localparam int CLK_NS      = 4;
	localparam int NORMAL_WAIT = 3;        // capture, push, ack
	localparam int LIMIT_CYC   = T_POWERUP + T_CLEAR + 3 * T_CMD + 40 * T_CMD + 1000;

	logic             clk;
	logic             rst_n;
	logic [CFG_W-1:0] init_cfg;
	logic             wb_cyc;
	logic             wb_stb;
	logic             wb_we;
	logic             wb_adr;
	logic [WB_DW-1:0] wb_dat_w;
	logic [WB_DW-1:0] wb_dat_r;
	logic             wb_ack;
	logic             lcd_e;
	logic             lcd_rs;
	logic             lcd_rw;
	logic [7:0]       lcd_data;
	logic             busy;

	lcd_cmd_t   exp_q[$];                  // appended by stimulus only
	int         errors;
	int         mon_errors;
	int         timing_errs;
	int         pulse_cnt;                 // also the monitor's read index
	int         tests_passed;
	int         tests_failed;
	logic       e_prev;
	logic       ack_prev;
	int         high_cnt;
	int         since_rise;
	logic [9:0] held;

	lcd_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(LIMIT_CYC * CLK_NS);
		$display("watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// bus monitor, sampled on the clock so values are settled
	initial begin
		mon_errors  = 0;
		timing_errs = 0;
		pulse_cnt   = 0;
		e_prev      = 1'b0;
		ack_prev    = 1'b0;
		high_cnt    = 0;
		since_rise  = 0;
		held        = '0;
		forever begin
			@(posedge clk);
			if (lcd_e && !e_prev) begin
				assert (pulse_cnt == 0 || since_rise >= T_CMD) else begin
					$display("FAILED lcd_e rise spacing: got 0x%0h, expected at least 0x%0h",
					         since_rise, T_CMD);
					timing_errs++;
				end
				since_rise = 0;
				high_cnt   = 0;
				held       = {lcd_rs, lcd_rw, lcd_data};
				if (pulse_cnt >= exp_q.size()) begin
					$display("e pulse seen with no word expected");
					mon_errors++;
				end else begin
					assert (held == 10'(exp_q[pulse_cnt])) else begin
						$display("FAILED lcd_rs/lcd_rw/lcd_data: got 0x%0h, expected 0x%0h",
						         held, 10'(exp_q[pulse_cnt]));
						mon_errors++;
					end
				end
				pulse_cnt++;
			end
			if (lcd_e) begin
				high_cnt++;
				assert ({lcd_rs, lcd_rw, lcd_data} == held) else begin
					$display("FAILED lcd_rs/lcd_rw/lcd_data while e high: got 0x%0h, expected 0x%0h",
					         {lcd_rs, lcd_rw, lcd_data}, held);
					timing_errs++;
				end
			end
			if (!lcd_e && e_prev) begin
				assert (high_cnt == T_EN_HIGH) else begin
					$display("FAILED lcd_e high time: got 0x%0h, expected 0x%0h",
					         high_cnt, T_EN_HIGH);
					timing_errs++;
				end
			end
			// bus parked at zero outside a slot
			if (!busy) begin
				assert ({lcd_e, lcd_rs, lcd_rw, lcd_data} == 11'h0) else begin
					$display("FAILED lcd_e/rs/rw/data when idle: got 0x%0h, expected 0x0",
					         {lcd_e, lcd_rs, lcd_rw, lcd_data});
					mon_errors++;
				end
			end
			assert (!(wb_ack && ack_prev)) else begin
				$display("wb_ack stayed high for more than one cycle");
				mon_errors++;
			end
			since_rise++;
			e_prev   = lcd_e;
			ack_prev = wb_ack;
		end
	end

	task automatic check_equal(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic expect_word(input logic [WB_DW-1:0] word);
		lcd_cmd_t w;
		w.rs   = word[9];
		w.rw   = word[8];
		w.data = word[7:0];
		exp_q.push_back(w);
	endtask

	task automatic wb_write(input logic adr, input logic [WB_DW-1:0] dat, output int waits);
		waits = 0;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		do begin
			@(negedge clk);
			waits++;
		end while (!wb_ack);
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(input logic adr, output logic [WB_DW-1:0] dat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= adr;
		do begin
			@(negedge clk);
		end while (!wb_ack);
		dat = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	// every expected word on the bus and the controller idle
	task automatic wait_drained();
		@(negedge clk);
		while (pulse_cnt < exp_q.size() || busy)
			@(negedge clk);
	endtask

	task automatic report_test(input string name, input bit ok);
		if (ok) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	initial begin
		logic [WB_DW-1:0] word;
		logic [WB_DW-1:0] rd;
		int               waits;
		int               mark;
		int               pulses_before;
		bit               saw_full;
		void'($urandom(45));
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		init_cfg     = 7'($urandom);
		rst_n        = 1'b0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = 1'b0;
		wb_dat_w     = '0;
		// function set, display control, clear, entry mode
		expect_word({8'h00, 4'b0011, init_cfg[6], init_cfg[5], 2'b00});
		expect_word({8'h00, 5'b00001, init_cfg[4], init_cfg[3], init_cfg[2]});
		expect_word(16'h0001);
		expect_word({8'h00, 6'b000001, init_cfg[1], init_cfg[0]});
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		mark = errors + mon_errors;
		@(negedge clk);
		check_equal("busy", 16'(busy), 16'h1);
		wait_drained();
		check_equal("init pulse count", 16'(pulse_cnt), 16'd4);
		report_test("1 init sequence", errors + mon_errors == mark);

		mark = errors + mon_errors;
		repeat (12) begin
			word = 16'($urandom_range(0, 1023));
			repeat ($urandom_range(0, 20)) @(posedge clk);
			wb_write(ADR_CMD, word, waits);
			expect_word(word);
		end
		wait_drained();
		check_equal("pulse count", 16'(pulse_cnt), 16'd16);
		report_test("2 random writes", errors + mon_errors == mark);

		mark     = errors + mon_errors;
		saw_full = 1'b0;
		repeat (FIFO_DEPTH + 3) begin
			word = 16'($urandom_range(0, 1023));
			wb_write(ADR_CMD, word, waits);
			expect_word(word);
			if (waits > NORMAL_WAIT && !saw_full) begin
				wb_read(ADR_STATUS, rd);
				check_equal("status level", 16'(rd[LVL_W-1:0]), 16'(FIFO_DEPTH));
				saw_full = 1'b1;
			end
		end
		assert (saw_full) else begin
			$display("no write had its ack held back by a full FIFO");
			errors++;
		end
		wait_drained();
		check_equal("pulse count", 16'(pulse_cnt), 16'd27);
		report_test("4 burst with back-pressure", errors + mon_errors == mark);

		mark = errors + mon_errors;
		repeat (3) begin
			word = 16'($urandom_range(0, 1023));
			wb_write(ADR_CMD, word, waits);
			expect_word(word);
		end
		wb_read(ADR_STATUS, rd);
		assert (int'(rd[LVL_W-1:0]) <= FIFO_DEPTH) else begin
			$display("FAILED status level: got 0x%0h, expected at most 0x%0h",
			         rd[LVL_W-1:0], FIFO_DEPTH);
			errors++;
		end
		check_equal("status busy", 16'(rd[8]), 16'h1);
		check_equal("status unused bits", rd & 16'hFEF0, 16'h0000);
		wait_drained();
		wb_read(ADR_STATUS, rd);
		check_equal("idle status", rd, 16'h0000);
		pulses_before = pulse_cnt;
		wb_write(ADR_STATUS, 16'h03ff, waits);
		repeat (2 * T_CMD) @(posedge clk);
		check_equal("pulses after status write", 16'(pulse_cnt - pulses_before), 16'd0);
		report_test("5 status reads", errors + mon_errors == mark);

		report_test("3 enable timing", timing_errs == 0 && pulse_cnt == 30);
		$display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
		if (tests_failed == 0 && errors + mon_errors + timing_errs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
src/lcd_pkg.sv
src/wb_cmd_slave.sv
src/cmd_fifo.sv
src/lcd_ctrl.sv
src/lcd_top.sv
testbench/tb_lcd_top.sv

// File: run.sh
#!/bin/sh
# build and run the LCD testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_lcd_top -f list.f -o tb_lcd_top_sim

out=$(./obj_dir/tb_lcd_top_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"
